//--- rtl/sram_pkg.sv
package sram_pkg;

	// host and chip widths
	localparam int ADDR_W = 20;
	localparam int SRAM_ADDR_W = 16;
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// sram window in host space, end is exclusive
	localparam addr_t MEM_BEGIN = 20'h10000;
	localparam addr_t MEM_END = 20'h20000;

	// request queue
	localparam int FIFO_DEPTH = 4;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	typedef struct packed {
		logic we;
		sram_addr_t addr;
		data_t data;
	} sram_req_t;

	// chip pins, strobes active low
	typedef struct packed {
		sram_addr_t addr;
		data_t dout;
		logic drive;
		logic ce_n;
		logic oe_n;
		logic we_n;
	} sram_pins_t;

	typedef enum logic [2:0] {
		ST_WAIT,
		ST_RD_SET_ADDR,
		ST_RD_DATA_GET,
		ST_RD_FINISH,
		ST_WR_SET_ADDR,
		ST_WR_SET_WE,
		ST_WR_FINISH
	} ctrl_state_t;

endpackage

//--- rtl/sram_window_decode.sv
module sram_window_decode (
	input  logic clk,
	input  logic rst,
	input  logic rd_strobe,
	input  logic wr_strobe,
	input  sram_pkg::addr_t addr,
	input  sram_pkg::data_t wdata,
	output logic push,
	output sram_pkg::sram_req_t req,
	output logic reject
);

	logic strobe;
	logic above_begin;
	logic below_end;
	logic in_window;
	sram_pkg::addr_t offset;

	assign strobe = rd_strobe | wr_strobe;

	// window check on the raw host address
	assign above_begin = (addr >= sram_pkg::MEM_BEGIN);
	assign below_end = (addr < sram_pkg::MEM_END);
	assign in_window = above_begin & below_end;

	// rebase into chip space
	assign offset = addr - sram_pkg::MEM_BEGIN;

	// accepted strobes go straight into the queue
	assign push = strobe & in_window;

	always_comb begin
		// both strobes at once count as a read
		req.we = wr_strobe & ~rd_strobe;
		req.addr = offset[sram_pkg::SRAM_ADDR_W-1:0];
		req.data = wdata;
	end

	// one cycle reject pulse for out of window strobes
	always_ff @(posedge clk) begin
		if (rst) begin
			reject <= 1'b0;
		end else begin
			reject <= strobe & ~in_window;
		end
	end

endmodule

//--- rtl/sram_req_fifo.sv
module sram_req_fifo (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  sram_pkg::sram_req_t req,
	input  logic pop,
	output sram_pkg::sram_req_t head,
	output logic not_empty,
	output logic busy
);

	sram_pkg::sram_req_t mem [sram_pkg::FIFO_DEPTH];

	sram_pkg::ptr_t wr_ptr;
	sram_pkg::ptr_t rd_ptr;
	sram_pkg::cnt_t count;

	logic full;
	logic do_push;
	logic do_pop;

	function automatic sram_pkg::ptr_t next_ptr(input sram_pkg::ptr_t ptr);
		if (ptr == sram_pkg::ptr_t'(sram_pkg::FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == sram_pkg::cnt_t'(sram_pkg::FIFO_DEPTH));
	assign not_empty = (count != '0);
	assign busy = full;

	// a push while full is dropped
	assign do_push = push & ~full;
	assign do_pop = pop & not_empty;

	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
		end
	end

	// push and pop together leave the count alone
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/sram_ctrl.sv
module sram_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic halt,
	input  sram_pkg::sram_req_t head,
	input  logic not_empty,
	output logic pop,
	output sram_pkg::sram_pins_t pins,
	input  sram_pkg::data_t sram_rdata,
	output logic rd_done,
	output sram_pkg::data_t rdata,
	output logic wr_done
);

	sram_pkg::ctrl_state_t state;
	sram_pkg::ctrl_state_t state_next;
	sram_pkg::sram_req_t cur;

	logic take;
	logic abort;

	// leave wait only with a request pending and no halt
	assign take = (state == sram_pkg::ST_WAIT) & not_empty & ~halt;
	assign pop = take;

	assign abort = halt & (state != sram_pkg::ST_WAIT);

	always_comb begin
		state_next = state;
		if (abort) begin
			state_next = sram_pkg::ST_WAIT;
		end else begin
			case (state)
				sram_pkg::ST_WAIT: begin
					if (take) begin
						state_next = head.we ? sram_pkg::ST_WR_SET_ADDR
							: sram_pkg::ST_RD_SET_ADDR;
					end
				end
				sram_pkg::ST_RD_SET_ADDR: state_next = sram_pkg::ST_RD_DATA_GET;
				sram_pkg::ST_RD_DATA_GET: state_next = sram_pkg::ST_RD_FINISH;
				sram_pkg::ST_RD_FINISH: state_next = sram_pkg::ST_WAIT;
				sram_pkg::ST_WR_SET_ADDR: state_next = sram_pkg::ST_WR_SET_WE;
				sram_pkg::ST_WR_SET_WE: state_next = sram_pkg::ST_WR_FINISH;
				sram_pkg::ST_WR_FINISH: state_next = sram_pkg::ST_WAIT;
				default: state_next = sram_pkg::ST_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sram_pkg::ST_WAIT;
		end else begin
			state <= state_next;
		end
	end

	// request held for the whole pin sequence
	always_ff @(posedge clk) begin
		if (take) begin
			cur <= head;
		end
	end

	// pin sequencing, done pulses last one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pins.drive <= 1'b0;
			pins.ce_n <= 1'b1;
			pins.oe_n <= 1'b1;
			pins.we_n <= 1'b1;
			rd_done <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			wr_done <= 1'b0;
			if (abort) begin
				// release the chip, nothing reported
				pins.drive <= 1'b0;
				pins.ce_n <= 1'b1;
				pins.oe_n <= 1'b1;
				pins.we_n <= 1'b1;
			end else begin
				case (state)
					sram_pkg::ST_WAIT: begin
						pins.drive <= 1'b0;
						pins.ce_n <= 1'b1;
						pins.oe_n <= 1'b1;
						pins.we_n <= 1'b1;
					end
					sram_pkg::ST_RD_SET_ADDR: begin
						pins.addr <= cur.addr;
						pins.ce_n <= 1'b0;
						pins.oe_n <= 1'b0;
						pins.we_n <= 1'b1;
					end
					sram_pkg::ST_RD_DATA_GET: begin
						rd_done <= 1'b1;
					end
					sram_pkg::ST_RD_FINISH: begin
						pins.ce_n <= 1'b1;
						pins.oe_n <= 1'b1;
					end
					sram_pkg::ST_WR_SET_ADDR: begin
						pins.addr <= cur.addr;
						pins.dout <= cur.data;
						pins.drive <= 1'b1;
						pins.ce_n <= 1'b0;
						pins.oe_n <= 1'b1;
					end
					sram_pkg::ST_WR_SET_WE: begin
						pins.we_n <= 1'b0;
					end
					sram_pkg::ST_WR_FINISH: begin
						// data still driven while we rises
						pins.we_n <= 1'b1;
						wr_done <= 1'b1;
					end
					default: begin
						pins.drive <= 1'b0;
						pins.ce_n <= 1'b1;
						pins.oe_n <= 1'b1;
						pins.we_n <= 1'b1;
					end
				endcase
			end
		end
	end

	// read data captured alongside rd_done
	always_ff @(posedge clk) begin
		if (state == sram_pkg::ST_RD_DATA_GET && !halt) begin
			rdata <= sram_rdata;
		end
	end

endmodule

//--- rtl/sram_subsys.sv
module sram_subsys (
	input  logic clk,
	input  logic rst,
	input  logic halt,
	input  logic rd_strobe,
	input  logic wr_strobe,
	input  sram_pkg::addr_t addr,
	input  sram_pkg::data_t wdata,
	input  sram_pkg::data_t sram_rdata,
	output logic busy,
	output logic reject,
	output logic rd_done,
	output sram_pkg::data_t rdata,
	output logic wr_done,
	output sram_pkg::sram_pins_t pins
);

	logic push;
	logic pop;
	logic not_empty;
	sram_pkg::sram_req_t req;
	sram_pkg::sram_req_t head;

	// host strobes to requests
	sram_window_decode decode0 (
		.clk(clk),
		.rst(rst),
		.rd_strobe(rd_strobe),
		.wr_strobe(wr_strobe),
		.addr(addr),
		.wdata(wdata),
		.push(push),
		.req(req),
		.reject(reject)
	);

	sram_req_fifo fifo0 (
		.clk(clk),
		.rst(rst),
		.push(push),
		.req(req),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.busy(busy)
	);

	// chip side sequencing
	sram_ctrl ctrl0 (
		.clk(clk),
		.rst(rst),
		.halt(halt),
		.head(head),
		.not_empty(not_empty),
		.pop(pop),
		.pins(pins),
		.sram_rdata(sram_rdata),
		.rd_done(rd_done),
		.rdata(rdata),
		.wr_done(wr_done)
	);

endmodule

//--- tb/sram_chip_model.sv
module sram_chip_model (
	input  sram_pkg::sram_pins_t pins,
	output sram_pkg::data_t rdata
);

	sram_pkg::data_t mem [1 << sram_pkg::SRAM_ADDR_W];

	// power up contents follow the whole address
	initial begin
		for (int i = 0; i < (1 << sram_pkg::SRAM_ADDR_W); i++) begin
			mem[sram_pkg::sram_addr_t'(i)] = sram_pkg::data_t'(i) ^ 16'h5aa5;
		end
	end

	// the chip only drives the bus when selected, reading and the host is off it
	assign rdata = (!pins.ce_n && !pins.oe_n && !pins.drive) ? mem[pins.addr] : '0;

	// data latched as we rises at the end of the write pulse
	always @(posedge pins.we_n) begin
		if (!pins.ce_n && pins.drive) begin
			mem[pins.addr] = pins.dout;
		end
	end

endmodule

//--- tb/sram_subsys_properties.sv
module sram_subsys_properties (
	input logic clk,
	input logic rst,
	input logic rd_strobe,
	input logic wr_strobe,
	input logic busy,
	input logic rd_done,
	input logic wr_done,
	input sram_pkg::sram_pins_t pins
);

	// write pulse only with the chip selected and data on the bus
	we_needs_select: assert property (@(posedge clk) disable iff (rst)
		!pins.we_n |-> (!pins.ce_n && pins.drive))
		else $error("we_n low while ce_n high or drive low");

	oe_we_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(!pins.oe_n && !pins.we_n))
		else $error("oe_n and we_n low together");

	done_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(rd_done && wr_done))
		else $error("rd_done and wr_done in the same cycle");

	// host must hold off while the queue is full
	no_strobe_when_busy: assert property (@(posedge clk) disable iff (rst)
		(rd_strobe || wr_strobe) |-> !busy)
		else $error("strobe issued while busy");

endmodule

bind sram_subsys sram_subsys_properties props0 (
	.clk(clk),
	.rst(rst),
	.rd_strobe(rd_strobe),
	.wr_strobe(wr_strobe),
	.busy(busy),
	.rd_done(rd_done),
	.wr_done(wr_done),
	.pins(pins)
);

//--- tb/sram_subsys_tb.sv
module sram_subsys_tb;

	localparam int WAIT_LIMIT = 200;
	localparam int NUM_PATS = 32;

	logic clk;
	logic rst;
	logic halt;
	logic rd_strobe;
	logic wr_strobe;
	sram_pkg::addr_t addr;
	sram_pkg::data_t wdata;
	sram_pkg::data_t sram_rdata;
	logic busy;
	logic reject;
	logic rd_done;
	sram_pkg::data_t rdata;
	logic wr_done;
	sram_pkg::sram_pins_t pins;

	// op[55:52] host addr[51:32] data[31:16] expect[15:0]
	logic [55:0] pats [NUM_PATS];

	int rd_count;
	int wr_count;
	int rej_count;
	int rd_exp;
	int wr_exp;
	sram_pkg::data_t last_rdata;
	logic [31:0] lcg_state;
	sram_pkg::addr_t fill_addr [$];
	sram_pkg::data_t fill_data [$];

	sram_subsys dut0 (
		.clk(clk),
		.rst(rst),
		.halt(halt),
		.rd_strobe(rd_strobe),
		.wr_strobe(wr_strobe),
		.addr(addr),
		.wdata(wdata),
		.sram_rdata(sram_rdata),
		.busy(busy),
		.reject(reject),
		.rd_done(rd_done),
		.rdata(rdata),
		.wr_done(wr_done),
		.pins(pins)
	);

	sram_chip_model model0 (
		.pins(pins),
		.rdata(sram_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic sram_pkg::data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic logic in_window(input sram_pkg::addr_t a);
		return (a >= sram_pkg::MEM_BEGIN) && (a < sram_pkg::MEM_END);
	endfunction

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input sram_pkg::data_t exp,
		input sram_pkg::data_t act);
		if (exp !== act) begin
			$display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("ERROR time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	// sample outputs mid cycle and count pulses
	task automatic step();
		@(negedge clk);
		if (rd_done) begin
			rd_count++;
			last_rdata = rdata;
		end
		if (wr_done) begin
			wr_count++;
		end
		if (reject) begin
			rej_count++;
		end
	endtask

	task automatic strobe_once(input logic rd, input logic wr, input sram_pkg::addr_t a,
		input sram_pkg::data_t d);
		@(posedge clk);
		rd_strobe <= rd;
		wr_strobe <= wr;
		addr <= a;
		wdata <= d;
		step();
		@(posedge clk);
		rd_strobe <= 1'b0;
		wr_strobe <= 1'b0;
		step();
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout waiting for busy to fall");
				stop_run();
			end
			step();
			n++;
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (rd_count != rd_exp || wr_count != wr_exp) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout waiting for done pulses, reads %0d of %0d, writes %0d of %0d",
					rd_count, rd_exp, wr_count, wr_exp);
				stop_run();
			end
			step();
			n++;
		end
	endtask

	task automatic do_write(input sram_pkg::addr_t a, input sram_pkg::data_t d);
		wait_not_busy();
		strobe_once(1'b0, 1'b1, a, d);
		wr_exp++;
	endtask

	task automatic do_read(input sram_pkg::addr_t a, input sram_pkg::data_t exp);
		sram_pkg::sram_addr_t sa;
		sa = sram_pkg::sram_addr_t'(a - sram_pkg::MEM_BEGIN);
		wait_not_busy();
		strobe_once(1'b1, 1'b0, a, '0);
		rd_exp++;
		wait_done();
		check_data("rdata", exp, last_rdata);
		check_data("model0.mem", exp, model0.mem[sa]);
	endtask

	task automatic expect_reject(input logic rd, input logic wr, input sram_pkg::addr_t a,
		input sram_pkg::data_t d);
		int rej_before;
		int i;
		wait_done();
		rej_before = rej_count;
		strobe_once(rd, wr, a, d);
		i = 0;
		while (rej_count == rej_before) begin
			if (i == WAIT_LIMIT) begin
				$display("timeout waiting for reject at address %h", a);
				stop_run();
			end
			step();
			i++;
		end
		for (i = 0; i < 6; i++) begin
			step();
		end
		check_flag("reject", 1'b0, reject);
		check_count("reject pulses", rej_before + 1, rej_count);
		check_count("rd_done pulses", rd_exp, rd_count);
		check_count("wr_done pulses", wr_exp, wr_count);
	endtask

	task automatic pause_idle(input int cycles);
		wait_done();
		for (int i = 0; i < cycles; i++) begin
			step();
			check_flag("rd_done", 1'b0, rd_done);
			check_flag("wr_done", 1'b0, wr_done);
			check_flag("pins.ce_n", 1'b1, pins.ce_n);
		end
	endtask

	// read aborted right after its take, filler writes queue behind the halt
	task automatic halt_read(input sram_pkg::addr_t a, input int n);
		int rd_before;
		int i;
		sram_pkg::addr_t fa;
		sram_pkg::data_t fd;
		wait_done();
		rd_before = rd_count;
		@(posedge clk);
		rd_strobe <= 1'b1;
		addr <= a;
		step();
		@(posedge clk);
		rd_strobe <= 1'b0;
		step();
		@(posedge clk);
		halt <= 1'b1;
		step();
		for (i = 1; i <= n; i++) begin
			fa = a + sram_pkg::addr_t'(i);
			fd = lcg_next();
			fill_addr.push_back(fa);
			fill_data.push_back(fd);
			wait_not_busy();
			strobe_once(1'b0, 1'b1, fa, fd);
		end
		if (n >= sram_pkg::FIFO_DEPTH) begin
			check_flag("busy", 1'b1, busy);
		end
		for (i = 0; i < 4; i++) begin
			step();
		end
		check_count("rd_done pulses", rd_before, rd_count);
		check_count("wr_done pulses", wr_exp, wr_count);
		check_flag("pins.ce_n", 1'b1, pins.ce_n);
		@(posedge clk);
		halt <= 1'b0;
		step();
		wr_exp += n;
		wait_done();
		for (i = 0; i < fill_addr.size(); i++) begin
			do_read(fill_addr[i], fill_data[i]);
		end
		fill_addr.delete();
		fill_data.delete();
	endtask

	initial begin
		int idx;
		logic [3:0] op;
		sram_pkg::addr_t a;
		sram_pkg::data_t d;
		sram_pkg::data_t e;
		rst = 1'b1;
		halt = 1'b0;
		rd_strobe = 1'b0;
		wr_strobe = 1'b0;
		addr = '0;
		wdata = '0;
		rd_count = 0;
		wr_count = 0;
		rej_count = 0;
		rd_exp = 0;
		wr_exp = 0;
		last_rdata = '0;
		lcg_state = 32'd50491;
		$readmemh("tb/sram_patterns.txt", pats);
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		step();
		idx = 0;
		while (idx < NUM_PATS && pats[idx][55:52] != 4'hf) begin
			op = pats[idx][55:52];
			a = pats[idx][51:32];
			d = pats[idx][31:16];
			e = pats[idx][15:0];
			case (op)
				4'h0: pause_idle(int'(d));
				4'h1: begin
					if (in_window(a)) begin
						do_write(a, d);
					end else begin
						expect_reject(1'b0, 1'b1, a, d);
					end
				end
				4'h2: begin
					if (in_window(a)) begin
						do_read(a, e);
					end else begin
						expect_reject(1'b1, 1'b0, a, '0);
					end
				end
				4'h3: halt_read(a, int'(d));
				default: begin
					$display("unknown opcode %h in pattern line %0d", op, idx);
					stop_run();
				end
			endcase
			idx++;
		end
		wait_done();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- tb/sram_patterns.txt
// op_addr_data_expect, op 0 pause, 1 write, 2 read, 3 halt read, f end
// addr is the host address, data is write data or a count, expect is read data
0_00000_0008_0000
2_10040_0000_5ae5
1_10040_beef_0000
2_10040_0000_beef
1_0ffff_1111_0000
2_20000_0000_0000
1_10100_0001_0000
1_10101_0002_0000
1_10100_0011_0000
1_10102_0003_0000
1_10103_0004_0000
1_1fffe_0005_0000
2_10100_0000_0011
2_10103_0000_0004
2_1fffe_0000_0005
3_12000_0004_0000
0_00000_0004_0000
2_12000_0000_7aa5
f_00000_0000_0000

//--- src.f
rtl/sram_pkg.sv
rtl/sram_window_decode.sv
rtl/sram_req_fifo.sv
rtl/sram_ctrl.sv
rtl/sram_subsys.sv
tb/sram_chip_model.sv
tb/sram_subsys_properties.sv
tb/sram_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module sram_subsys_tb -f src.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
